// ==== rtl/mfp_ahb_pkg.sv ====
package mfp_ahb_pkg;

    // transfer type codes
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    // transfer size codes
    localparam logic [2:0] hsize_byte = 3'b000;
    localparam logic [2:0] hsize_half = 3'b001;
    localparam logic [2:0] hsize_word = 3'b010;

    // address map, every region is 4 KB
    localparam logic [31:0] ram_base          = 32'h0000_0000;
    localparam int          ram_addr_width    = 12;
    localparam int          ram_words         = 2 ** (ram_addr_width - 2);
    localparam logic [31:0] gpio_base         = 32'h1f80_0000;
    localparam logic [31:0] uart_base         = 32'h1f81_0000;
    localparam logic [31:0] slave_region_mask = 32'hffff_f000;

    // gpio register offsets
    localparam logic [11:0] gpio_red_leds_off   = 12'h000;
    localparam logic [11:0] gpio_green_leds_off = 12'h004;
    localparam logic [11:0] gpio_switches_off   = 12'h008;
    localparam logic [11:0] gpio_buttons_off    = 12'h00c;

    // uart register offsets
    localparam logic [11:0] uart_data_off   = 12'h000;
    localparam logic [11:0] uart_status_off = 12'h004;

    // serial bit timing, 8N1 frame of ten bits
    localparam int                         uart_clks_per_bit = 16;
    localparam int                         uart_baud_width   = $clog2(uart_clks_per_bit);
    localparam logic [uart_baud_width-1:0] uart_baud_last    =
        uart_baud_width'(uart_clks_per_bit - 1);
    localparam logic [3:0]                 uart_last_bit     = 4'd9;

    typedef enum logic [1:0] {sel_none, sel_ram, sel_gpio, sel_uart} slave_sel_t;

endpackage

// ==== rtl/mfp_ahb_ram.sv ====
module mfp_ahb_ram (
    input  logic        hclk,
    input  logic        rst,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [ 1:0] htrans,
    input  logic        hwrite,
    input  logic [ 2:0] hsize,
    input  logic [31:0] hwdata,
    input  logic        hready,
    output logic [31:0] hrdata,
    output logic        hreadyout
);

    logic [31:0] mem [mfp_ahb_pkg::ram_words];

    logic                                  accept;
    logic                                  wr_pend;
    logic [mfp_ahb_pkg::ram_addr_width-1:0] addr_q;
    logic [ 2:0]                           size_q;
    logic [ 3:0]                           byte_en;
    logic                                  wr_now;
    logic                                  same_word;
    logic [31:0]                           rdata_q;

    assign accept = hsel && hready && ((htrans == mfp_ahb_pkg::htrans_nonseq)
                                    || (htrans == mfp_ahb_pkg::htrans_seq));

    always_ff @(posedge hclk) begin
        if (rst)
            wr_pend <= 1'b0;
        else if (hready)
            wr_pend <= accept && hwrite;
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            addr_q <= haddr[mfp_ahb_pkg::ram_addr_width-1:0];
            size_q <= hsize;
        end
    end

    // lane enables from size and low address bits
    always_comb begin
        case (size_q)
            mfp_ahb_pkg::hsize_byte: byte_en = 4'b0001 << addr_q[1:0];
            mfp_ahb_pkg::hsize_half: byte_en = addr_q[1] ? 4'b1100 : 4'b0011;
            default:                 byte_en = 4'b1111;
        endcase
    end

    assign wr_now    = wr_pend && hready;
    assign same_word = (addr_q[mfp_ahb_pkg::ram_addr_width-1:2]
                     == haddr[mfp_ahb_pkg::ram_addr_width-1:2]);

    always_ff @(posedge hclk) begin
        if (wr_now) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i])
                    mem[addr_q[mfp_ahb_pkg::ram_addr_width-1:2]][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    // read in the address phase, with write lanes forwarded
    always_ff @(posedge hclk) begin
        if (accept && !hwrite) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_now && same_word && byte_en[i])
                    rdata_q[8*i +: 8] <= hwdata[8*i +: 8];
                else
                    rdata_q[8*i +: 8] <= mem[haddr[mfp_ahb_pkg::ram_addr_width-1:2]][8*i +: 8];
            end
        end
    end

    assign hrdata    = rdata_q;
    assign hreadyout = 1'b1;

endmodule

// ==== rtl/mfp_ahb_gpio.sv ====
module mfp_ahb_gpio (
    input  logic        hclk,
    input  logic        rst,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [ 1:0] htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    input  logic        hready,
    output logic [31:0] hrdata,
    output logic        hreadyout,
    input  logic [17:0] io_switches,
    input  logic [ 4:0] io_buttons,
    output logic [17:0] io_red_leds,
    output logic [ 8:0] io_green_leds
);

    logic        accept;
    logic        wr_pend;
    logic [11:0] off_q;
    logic [17:0] red_q;
    logic [ 8:0] green_q;
    logic [17:0] switches_q;
    logic [ 4:0] buttons_q;

    assign accept = hsel && hready && ((htrans == mfp_ahb_pkg::htrans_nonseq)
                                    || (htrans == mfp_ahb_pkg::htrans_seq));

    always_ff @(posedge hclk) begin
        if (rst)
            wr_pend <= 1'b0;
        else if (hready)
            wr_pend <= accept && hwrite;
    end

    // inputs sampled at the end of the address phase
    always_ff @(posedge hclk) begin
        if (accept) begin
            off_q      <= haddr[11:0];
            switches_q <= io_switches;
            buttons_q  <= io_buttons;
        end
    end

    always_ff @(posedge hclk) begin
        if (rst) begin
            red_q   <= '0;
            green_q <= '0;
        end else if (wr_pend && hready) begin
            if (off_q[11:2] == mfp_ahb_pkg::gpio_red_leds_off[11:2])
                red_q <= hwdata[17:0];
            if (off_q[11:2] == mfp_ahb_pkg::gpio_green_leds_off[11:2])
                green_q <= hwdata[8:0];
        end
    end

    always_comb begin
        case (off_q[11:2])
            mfp_ahb_pkg::gpio_red_leds_off[11:2]:   hrdata = {14'b0, red_q};
            mfp_ahb_pkg::gpio_green_leds_off[11:2]: hrdata = {23'b0, green_q};
            mfp_ahb_pkg::gpio_switches_off[11:2]:   hrdata = {14'b0, switches_q};
            mfp_ahb_pkg::gpio_buttons_off[11:2]:    hrdata = {27'b0, buttons_q};
            default:                                hrdata = 32'b0;
        endcase
    end

    assign hreadyout     = 1'b1;
    assign io_red_leds   = red_q;
    assign io_green_leds = green_q;

endmodule

// ==== rtl/mfp_ahb_uart_tx.sv ====
module mfp_ahb_uart_tx (
    input  logic        hclk,
    input  logic        rst,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [ 1:0] htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    input  logic        hready,
    output logic [31:0] hrdata,
    output logic        hreadyout,
    output logic        uart_tx
);

    logic                                   accept;
    logic                                   wr_pend;
    logic [11:0]                            off_q;
    logic                                   busy;
    logic [ 9:0]                            tx_shift;
    logic [ 3:0]                            bit_cnt;
    logic [mfp_ahb_pkg::uart_baud_width-1:0] baud_cnt;

    assign accept = hsel && hready && ((htrans == mfp_ahb_pkg::htrans_nonseq)
                                    || (htrans == mfp_ahb_pkg::htrans_seq));

    // only data register writes start a frame
    always_ff @(posedge hclk) begin
        if (rst)
            wr_pend <= 1'b0;
        else if (hready)
            wr_pend <= accept && hwrite
                    && (haddr[11:2] == mfp_ahb_pkg::uart_data_off[11:2]);
    end

    always_ff @(posedge hclk) begin
        if (accept)
            off_q <= haddr[11:0];
    end

    // stall a data write until the running frame is out
    assign hreadyout = !(wr_pend && busy);

    always_ff @(posedge hclk) begin
        if (rst) begin
            busy     <= 1'b0;
            tx_shift <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (wr_pend && hready) begin
            // stop bit, data lsb first, start bit
            busy     <= 1'b1;
            tx_shift <= {1'b1, hwdata[7:0], 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (busy) begin
            if (baud_cnt == mfp_ahb_pkg::uart_baud_last) begin
                baud_cnt <= '0;
                tx_shift <= {1'b1, tx_shift[9:1]};
                if (bit_cnt == mfp_ahb_pkg::uart_last_bit)
                    busy <= 1'b0;
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    assign uart_tx = tx_shift[0];

    always_comb begin
        if (off_q[11:2] == mfp_ahb_pkg::uart_status_off[11:2])
            hrdata = {31'b0, busy};
        else
            hrdata = 32'b0;
    end

endmodule

// ==== rtl/mfp_ahb_lite_matrix.sv ====
module mfp_ahb_lite_matrix (
    input  logic        hclk,
    input  logic        rst,
    input  logic [31:0] haddr,
    input  logic [ 1:0] htrans,
    input  logic        hwrite,
    input  logic [ 2:0] hsize,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    input  logic [17:0] io_switches,
    input  logic [ 4:0] io_buttons,
    output logic [17:0] io_red_leds,
    output logic [ 8:0] io_green_leds,
    output logic        uart_tx
);

    typedef enum logic [1:0] {def_idle, def_err_wait, def_err_last} def_state_t;

    mfp_ahb_pkg::slave_sel_t addr_sel;
    mfp_ahb_pkg::slave_sel_t data_sel;
    def_state_t              def_state;

    logic        trans_valid;
    logic        hsel_ram;
    logic        hsel_gpio;
    logic        hsel_uart;
    logic [31:0] ram_hrdata;
    logic [31:0] gpio_hrdata;
    logic [31:0] uart_hrdata;
    logic        ram_hreadyout;
    logic        gpio_hreadyout;
    logic        uart_hreadyout;
    logic        def_hreadyout;
    logic        def_hresp;

    assign trans_valid = (htrans == mfp_ahb_pkg::htrans_nonseq)
                      || (htrans == mfp_ahb_pkg::htrans_seq);

    always_comb begin
        if ((haddr & mfp_ahb_pkg::slave_region_mask) == mfp_ahb_pkg::ram_base)
            addr_sel = mfp_ahb_pkg::sel_ram;
        else if ((haddr & mfp_ahb_pkg::slave_region_mask) == mfp_ahb_pkg::gpio_base)
            addr_sel = mfp_ahb_pkg::sel_gpio;
        else if ((haddr & mfp_ahb_pkg::slave_region_mask) == mfp_ahb_pkg::uart_base)
            addr_sel = mfp_ahb_pkg::sel_uart;
        else
            addr_sel = mfp_ahb_pkg::sel_none;
    end

    assign hsel_ram  = (addr_sel == mfp_ahb_pkg::sel_ram);
    assign hsel_gpio = (addr_sel == mfp_ahb_pkg::sel_gpio);
    assign hsel_uart = (addr_sel == mfp_ahb_pkg::sel_uart);

    // slave owning the data phase, idle transfers land on none
    always_ff @(posedge hclk) begin
        if (rst)
            data_sel <= mfp_ahb_pkg::sel_none;
        else if (hready)
            data_sel <= trans_valid ? addr_sel : mfp_ahb_pkg::sel_none;
    end

    // default slave: error wait cycle, then error completion
    always_ff @(posedge hclk) begin
        if (rst) begin
            def_state <= def_idle;
        end else begin
            case (def_state)
                def_err_wait: def_state <= def_err_last;
                default: begin
                    if (hready && trans_valid && addr_sel == mfp_ahb_pkg::sel_none)
                        def_state <= def_err_wait;
                    else
                        def_state <= def_idle;
                end
            endcase
        end
    end

    assign def_hreadyout = (def_state != def_err_wait);
    assign def_hresp     = (def_state != def_idle);

    always_comb begin
        case (data_sel)
            mfp_ahb_pkg::sel_ram: begin
                hrdata = ram_hrdata;
                hready = ram_hreadyout;
                hresp  = 1'b0;
            end
            mfp_ahb_pkg::sel_gpio: begin
                hrdata = gpio_hrdata;
                hready = gpio_hreadyout;
                hresp  = 1'b0;
            end
            mfp_ahb_pkg::sel_uart: begin
                hrdata = uart_hrdata;
                hready = uart_hreadyout;
                hresp  = 1'b0;
            end
            default: begin
                hrdata = 32'b0;
                hready = def_hreadyout;
                hresp  = def_hresp;
            end
        endcase
    end

    mfp_ahb_ram ahb_ram (
        .hclk      ( hclk          ),
        .rst       ( rst           ),
        .hsel      ( hsel_ram      ),
        .haddr     ( haddr         ),
        .htrans    ( htrans        ),
        .hwrite    ( hwrite        ),
        .hsize     ( hsize         ),
        .hwdata    ( hwdata        ),
        .hready    ( hready        ),
        .hrdata    ( ram_hrdata    ),
        .hreadyout ( ram_hreadyout )
    );

    mfp_ahb_gpio ahb_gpio (
        .hclk          ( hclk           ),
        .rst           ( rst            ),
        .hsel          ( hsel_gpio      ),
        .haddr         ( haddr          ),
        .htrans        ( htrans         ),
        .hwrite        ( hwrite         ),
        .hwdata        ( hwdata         ),
        .hready        ( hready         ),
        .hrdata        ( gpio_hrdata    ),
        .hreadyout     ( gpio_hreadyout ),
        .io_switches   ( io_switches    ),
        .io_buttons    ( io_buttons     ),
        .io_red_leds   ( io_red_leds    ),
        .io_green_leds ( io_green_leds  )
    );

    mfp_ahb_uart_tx ahb_uart_tx (
        .hclk      ( hclk           ),
        .rst       ( rst            ),
        .hsel      ( hsel_uart      ),
        .haddr     ( haddr          ),
        .htrans    ( htrans         ),
        .hwrite    ( hwrite         ),
        .hwdata    ( hwdata         ),
        .hready    ( hready         ),
        .hrdata    ( uart_hrdata    ),
        .hreadyout ( uart_hreadyout ),
        .uart_tx   ( uart_tx        )
    );

endmodule

// ==== rtl/mfp_system.sv ====
module mfp_system (
    input  logic        hclk,
    input  logic        rst,

    input  logic [31:0] haddr,
    input  logic [ 1:0] htrans,
    input  logic        hwrite,
    input  logic [ 2:0] hsize,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,

    input  logic [17:0] io_switches,
    input  logic [ 4:0] io_buttons,
    output logic [17:0] io_red_leds,
    output logic [ 8:0] io_green_leds,

    output logic        uart_tx
);

    // bus master port comes straight in, core not present
    mfp_ahb_lite_matrix ahb_lite_matrix (
        .hclk          ( hclk          ),
        .rst           ( rst           ),
        .haddr         ( haddr         ),
        .htrans        ( htrans        ),
        .hwrite        ( hwrite        ),
        .hsize         ( hsize         ),
        .hwdata        ( hwdata        ),
        .hrdata        ( hrdata        ),
        .hready        ( hready        ),
        .hresp         ( hresp         ),

        .io_switches   ( io_switches   ),
        .io_buttons    ( io_buttons    ),
        .io_red_leds   ( io_red_leds   ),
        .io_green_leds ( io_green_leds ),

        .uart_tx       ( uart_tx       )
    );

endmodule

// ==== dv/mfp_ahb_master.svh ====
`ifndef MFP_AHB_MASTER_SVH
`define MFP_AHB_MASTER_SVH

task automatic step_cycle();
    @(posedge hclk);
    #1;
endtask

// counts the cycles spent with hready low
task automatic await_hready(output int waits);
    waits = 0;
    while (hready !== 1'b1) begin
        if (waits >= bus_timeout)
            wait_timed_out("hready to go high");
        step_cycle();
        waits++;
    end
endtask

// one address phase, then the bus is left idle
task automatic start_transfer(input logic [31:0] addr, input logic write,
                              input logic [2:0] size);
    int waits;
    await_hready(waits);
    haddr  = addr;
    htrans = mfp_ahb_pkg::htrans_nonseq;
    hwrite = write;
    hsize  = size;
    step_cycle();
    htrans = mfp_ahb_pkg::htrans_idle;
endtask

task automatic write_transfer(input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] data, output int waits);
    start_transfer(addr, 1'b1, size);
    hwdata = data;
    await_hready(waits);
    assert (hresp === 1'b0)
        else value_mismatch($sformatf("write to %h got an error response", addr));
    step_cycle();
endtask

task automatic read_transfer(input logic [31:0] addr, input logic [2:0] size,
                             output logic [31:0] data);
    int waits;
    start_transfer(addr, 1'b0, size);
    await_hready(waits);
    data = hrdata;
    assert (hresp === 1'b0)
        else value_mismatch($sformatf("read from %h got an error response", addr));
    step_cycle();
endtask

// unmapped address, two cycle error response
task automatic error_transfer(input logic [31:0] addr, input logic write);
    start_transfer(addr, write, mfp_ahb_pkg::hsize_word);
    hwdata = $urandom;
    assert (hready === 1'b0 && hresp === 1'b1)
        else value_mismatch($sformatf("%h first error cycle hready %b hresp %b",
                                      addr, hready, hresp));
    step_cycle();
    assert (hready === 1'b1 && hresp === 1'b1)
        else value_mismatch($sformatf("%h last error cycle hready %b hresp %b",
                                      addr, hready, hresp));
    step_cycle();
    assert (hready === 1'b1 && hresp === 1'b0)
        else value_mismatch($sformatf("bus not idle after error at %h", addr));
endtask

`endif

// ==== dv/tb_mfp_system.sv ====
module tb_mfp_system;

    localparam int bus_timeout = 400;
    localparam int bit_cycles  = mfp_ahb_pkg::uart_clks_per_bit;

    logic        hclk;
    logic        rst;
    logic [31:0] haddr;
    logic [ 1:0] htrans;
    logic        hwrite;
    logic [ 2:0] hsize;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic [17:0] io_switches;
    logic [ 4:0] io_buttons;
    logic [17:0] io_red_leds;
    logic [ 8:0] io_green_leds;
    logic        uart_tx;

    logic [31:0] ram_model [int];
    int          ram_words_written [$];
    logic [ 7:0] uart_expected [$];

    mfp_system DUT (.*);

    always #4 hclk = ~hclk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation aborted");
    endtask

    task automatic value_mismatch(input string what);
        abort_run($sformatf("FAILED at time %0t: %s", $time, what));
    endtask

    task automatic wait_timed_out(input string what);
        abort_run($sformatf("Timeout: gave up waiting for %s", what));
    endtask

    `include "mfp_ahb_master.svh"

    // little endian lanes touched by a write of this size
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [1:0] lane,
                                                input logic [2:0] size, input logic [31:0] data);
        logic [31:0] result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (size == mfp_ahb_pkg::hsize_word
                    || (size == mfp_ahb_pkg::hsize_half && (i / 2) == lane[1])
                    || (size == mfp_ahb_pkg::hsize_byte && i == lane))
                result[8*i +: 8] = data[8*i +: 8];
        end
        return result;
    endfunction

    task automatic store_ram(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        int waits;
        int index;
        index = int'(addr[11:2]);
        write_transfer(addr, size, data, waits);
        ram_model[index] = merge_lanes(ram_model.exists(index) ? ram_model[index] : 32'h0,
                                       addr[1:0], size, data);
    endtask

    task automatic check_ram_word(input int index);
        logic [31:0] data;
        read_transfer(32'(index) * 4, mfp_ahb_pkg::hsize_word, data);
        assert (data === ram_model[index])
            else value_mismatch($sformatf("RAM word %0d read %h, expected %h",
                                          index, data, ram_model[index]));
    endtask

    // serial monitor sampling each bit in its middle
    task automatic receive_frame();
        logic [7:0] data;
        logic [7:0] expected;
        int         waited;
        waited = 0;
        do begin
            @(negedge hclk);
            waited++;
            if (waited > bus_timeout)
                wait_timed_out("a start bit on uart_tx");
        end while (uart_tx !== 1'b0);
        repeat (bit_cycles / 2) @(negedge hclk);
        assert (uart_tx === 1'b0) else value_mismatch("start bit ended early");
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(negedge hclk);
            data[i] = uart_tx;
        end
        repeat (bit_cycles) @(negedge hclk);
        assert (uart_tx === 1'b1) else value_mismatch("stop bit not high");
        expected = uart_expected.pop_front();
        assert (data === expected)
            else value_mismatch($sformatf("uart byte %h, expected %h", data, expected));
    endtask

    task automatic poll_uart_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            if (polls > 10 * bit_cycles)
                wait_timed_out("the UART busy bit to clear");
            read_transfer(mfp_ahb_pkg::uart_base + mfp_ahb_pkg::uart_status_off,
                          mfp_ahb_pkg::hsize_word, status);
            polls++;
        end while (status[0]);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        logic [31:0] second;
        int          waits;
        int          idx;
        void'($urandom(32'hd0490df4));
        hclk        = 1'b0;
        rst         = 1'b1;
        haddr       = '0;
        htrans      = mfp_ahb_pkg::htrans_idle;
        hwrite      = 1'b0;
        hsize       = mfp_ahb_pkg::hsize_word;
        hwdata      = '0;
        io_switches = '0;
        io_buttons  = '0;
        repeat (8) @(posedge hclk);
        #1;
        rst = 1'b0;

        assert (hready === 1'b1 && hresp === 1'b0 && io_red_leds === '0
                && io_green_leds === '0 && uart_tx === 1'b1)
            else value_mismatch("outputs wrong after reset");

        for (int n = 0; n < 24; n++) begin
            idx = $urandom_range(mfp_ahb_pkg::ram_words - 1);
            if (!ram_model.exists(idx))
                ram_words_written.push_back(idx);
            store_ram(32'(idx) * 4, mfp_ahb_pkg::hsize_word, $urandom);
        end
        foreach (ram_model[w])
            check_ram_word(w);
        for (int n = 0; n < 16; n++) begin
            idx = ram_words_written[$urandom_range(ram_words_written.size() - 1)];
            if (n % 2 == 0)
                store_ram(32'(idx) * 4 + $urandom_range(3), mfp_ahb_pkg::hsize_byte, $urandom);
            else
                store_ram(32'(idx) * 4 + 2 * $urandom_range(1), mfp_ahb_pkg::hsize_half,
                          $urandom);
            check_ram_word(idx);
        end

        value = $urandom;
        write_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_red_leds_off,
                       mfp_ahb_pkg::hsize_word, value, waits);
        read_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_red_leds_off,
                      mfp_ahb_pkg::hsize_word, data);
        assert (io_red_leds === value[17:0] && data === {14'b0, value[17:0]})
            else value_mismatch($sformatf("red leds %h read %h for %h", io_red_leds, data, value));
        value = $urandom;
        write_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_green_leds_off,
                       mfp_ahb_pkg::hsize_word, value, waits);
        read_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_green_leds_off,
                      mfp_ahb_pkg::hsize_word, data);
        assert (io_green_leds === value[8:0] && data === {23'b0, value[8:0]})
            else value_mismatch($sformatf("green leds %h read %h for %h",
                                          io_green_leds, data, value));
        io_switches = 18'($urandom);
        read_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_switches_off,
                      mfp_ahb_pkg::hsize_word, data);
        assert (data === {14'b0, io_switches}) else value_mismatch("switch read wrong");
        io_buttons = 5'($urandom);
        read_transfer(mfp_ahb_pkg::gpio_base + mfp_ahb_pkg::gpio_buttons_off,
                      mfp_ahb_pkg::hsize_word, data);
        assert (data === {27'b0, io_buttons}) else value_mismatch("button read wrong");

        for (int n = 0; n < 2; n++) begin
            value = $urandom;
            uart_expected.push_back(value[7:0]);
            fork
                begin
                    write_transfer(mfp_ahb_pkg::uart_base + mfp_ahb_pkg::uart_data_off,
                                   mfp_ahb_pkg::hsize_word, value, waits);
                    read_transfer(mfp_ahb_pkg::uart_base + mfp_ahb_pkg::uart_status_off,
                                  mfp_ahb_pkg::hsize_word, data);
                    assert (data === 32'd1) else value_mismatch("status not busy mid frame");
                end
                receive_frame();
            join
            poll_uart_idle();
        end

        // second data phase starts one cycle after the first frame does
        value  = $urandom;
        second = $urandom;
        uart_expected.push_back(value[7:0]);
        uart_expected.push_back(second[7:0]);
        fork
            begin
                write_transfer(mfp_ahb_pkg::uart_base + mfp_ahb_pkg::uart_data_off,
                               mfp_ahb_pkg::hsize_word, value, waits);
                write_transfer(mfp_ahb_pkg::uart_base + mfp_ahb_pkg::uart_data_off,
                               mfp_ahb_pkg::hsize_word, second, waits);
                assert (waits == 10 * bit_cycles - 1)
                    else value_mismatch($sformatf("second uart write stalled %0d cycles", waits));
            end
            begin
                receive_frame();
                receive_frame();
            end
        join
        poll_uart_idle();

        error_transfer(32'h4000_0000, 1'b0);
        error_transfer(32'h2000_0100, 1'b1);
        store_ram(32'h0000_0ff0, mfp_ahb_pkg::hsize_word, $urandom);
        check_ram_word(32'h0ff0 / 4);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+dv
rtl/mfp_ahb_pkg.sv
rtl/mfp_ahb_ram.sv
rtl/mfp_ahb_gpio.sv
rtl/mfp_ahb_uart_tx.sv
rtl/mfp_ahb_lite_matrix.sv
rtl/mfp_system.sv
dv/tb_mfp_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_mfp_system -o tb_mfp_system &&
./obj_dir/tb_mfp_system | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
